// File: src/hubLinear_cfg.svh
`ifndef HUBLINEAR_CFG_SVH
`define HUBLINEAR_CFG_SVH

// Layer dimensions.
`define HL_IDIM 4
`define HL_ODIM 2

// Feature, weight and random number width; one window is 2**HL_IWID cycles.
`define HL_IWID 8
`define HL_OWID 8

// Register stages in each popcount tree.
`define HL_POP_STAGES 2

// Per-cycle count width and the accumulator width built on it.
`define HL_CNT_WID ($clog2(`HL_IDIM) + 1)
`define HL_ACC_WID (`HL_CNT_WID + `HL_IWID)

`endif

// File: src/hubLinearPkg.sv
`include "hubLinear_cfg.svh"

package hubLinearPkg;

    // Input features, one word per input.
    typedef logic [`HL_IWID-1:0] featureVec_t [`HL_IDIM];

    // Weight index is output * IDIM + input.
    typedef logic [`HL_IWID-1:0] weightVec_t [`HL_ODIM * `HL_IDIM];

    typedef logic [`HL_CNT_WID-1:0] countVec_t [`HL_ODIM];

    typedef logic [`HL_ACC_WID-1:0] accVec_t [`HL_ODIM];

    // Bank currently accumulating.
    typedef enum logic {
        bankA = 1'b0,
        bankB = 1'b1
    } accBank_e;

endpackage

// File: src/sobolRng.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module sobolRng (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    output logic [`HL_IWID-1:0] sobolSeq
);

    localparam int Wid = `HL_IWID;
    localparam int PosWid = (Wid > 1) ? $clog2(Wid) : 1;

    logic [Wid-1:0]    index;
    logic [PosWid-1:0] zeroPos;
    logic              zeroFound;
    logic [Wid-1:0]    direction;

    // Lowest zero bit of the index picks the direction number.
    // An all-ones index wraps with the last one, closing the period at zero.
    always_comb begin
        zeroPos = PosWid'(Wid - 1);
        zeroFound = 1'b0;
        for (int k = 0; k < Wid; k++) begin
            if (!zeroFound && !index[k]) begin
                zeroPos = PosWid'(k);
                zeroFound = 1'b1;
            end
        end
    end

    // First dimension: direction number k is a single bit, MSB first.
    assign direction = {1'b1, {(Wid - 1){1'b0}}} >> zeroPos;

    always_ff @(posedge clk) begin
        if (reset) begin
            index <= '0;
            sobolSeq <= '0;
        end else if (enable) begin
            index <= index + 1'b1;
            sobolSeq <= sobolSeq ^ direction;
        end
    end

endmodule

// File: src/weightBuffer.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module weightBuffer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  hubLinearPkg::weightVec_t iWeig,
    output hubLinearPkg::weightVec_t oWeig
);

    localparam int NumWeig = `HL_ODIM * `HL_IDIM;

    // All weights are captured together and held until the next load.
    always_ff @(posedge clk) begin
        if (reset) begin
            oWeig <= '{default: '0};
        end else if (load) begin
            for (int w = 0; w < NumWeig; w++) begin
                oWeig[w] <= iWeig[w];
            end
        end
    end

endmodule

// File: src/bitstreamEncoder.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module bitstreamEncoder (
    input  logic                      clk,
    input  logic                      reset,
    input  hubLinearPkg::featureVec_t iFmap,
    output logic [`HL_IDIM-1:0]       iBit
);

    logic [`HL_IWID-1:0] inRng;

    // One generator is shared by every input feature.
    sobolRng u_inRng (
        .clk      (clk),
        .reset    (reset),
        .enable   (1'b1),
        .sobolSeq (inRng)
    );

    // A full period emits exactly iFmap ones per input.
    for (genvar i = 0; i < `HL_IDIM; i++) begin : genCmp
        assign iBit[i] = (iFmap[i] > inRng);
    end

endmodule

// File: src/hubMultiplierArray.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hubMultiplierArray (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [`HL_IDIM-1:0]               iBit,
    input  hubLinearPkg::weightVec_t          iWeig,
    output logic [`HL_ODIM*`HL_IDIM-1:0]      oBit
);

    // Weight generators are shared by all outputs using the same input.
    logic [`HL_IWID-1:0] wRng [`HL_IDIM];

    for (genvar i = 0; i < `HL_IDIM; i++) begin : genWeigRng
        // Advances only on input ones, so the weight is sampled
        // once per input one in a low-discrepancy order.
        sobolRng u_weigRng (
            .clk      (clk),
            .reset    (reset),
            .enable   (iBit[i]),
            .sobolSeq (wRng[i])
        );
    end

    for (genvar o = 0; o < `HL_ODIM; o++) begin : genOut
        for (genvar i = 0; i < `HL_IDIM; i++) begin : genIn
            assign oBit[o * `HL_IDIM + i] =
                iBit[i] & (iWeig[o * `HL_IDIM + i] > wRng[i]);
        end
    end

endmodule

// File: src/popcountTree.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module popcountTree (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`HL_IDIM-1:0]    iBits,
    output logic [`HL_CNT_WID-1:0] oCount
);

    localparam int CntWid = `HL_CNT_WID;
    localparam int Levels = $clog2(`HL_IDIM);
    localparam int Leaves = 1 << Levels;
    localparam int TreeRegs = (`HL_POP_STAGES < Levels) ? `HL_POP_STAGES : Levels;
    localparam int TailRegs = `HL_POP_STAGES - TreeRegs;

    // Heap-ordered tree: node 1 is the root, leaves start at Leaves.
    logic [CntWid-1:0] node [1:2*Leaves-1];

    for (genvar n = 0; n < Leaves; n++) begin : genLeaf
        if (n < `HL_IDIM) begin : genBit
            always_comb node[Leaves + n] = CntWid'(iBits[n]);
        end else begin : genPad
            always_comb node[Leaves + n] = '0;
        end
    end

    // The lowest TreeRegs levels are registered, keeping every path balanced.
    for (genvar n = 1; n < Leaves; n++) begin : genNode
        localparam int Height = Levels - ($clog2(n + 1) - 1);
        if (Height <= TreeRegs) begin : genReg
            always_ff @(posedge clk) begin
                if (reset) begin
                    node[n] <= '0;
                end else begin
                    node[n] <= node[2*n] + node[2*n+1];
                end
            end
        end else begin : genComb
            always_comb node[n] = node[2*n] + node[2*n+1];
        end
    end

    // Stages beyond the tree depth become a delay line on the root.
    if (TailRegs > 0) begin : genTail
        logic [CntWid-1:0] tail [TailRegs];
        always_ff @(posedge clk) begin
            if (reset) begin
                tail <= '{default: '0};
            end else begin
                tail[0] <= node[1];
                for (int k = 1; k < TailRegs; k++) begin
                    tail[k] <= tail[k-1];
                end
            end
        end
        assign oCount = tail[TailRegs-1];
    end else begin : genNoTail
        assign oCount = node[1];
    end

endmodule

// File: src/pingPongAccumulator.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module pingPongAccumulator (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sel,
    input  logic                     clear,
    input  hubLinearPkg::countVec_t  iCount,
    output hubLinearPkg::accVec_t    oHeld
);

    import hubLinearPkg::*;

    localparam int AccWid = `HL_ACC_WID;

    accBank_e accBank;
    accVec_t  accA;
    accVec_t  accB;

    assign accBank = sel ? bankB : bankA;

    // Only the accumulating bank changes; the other one holds its result.
    always_ff @(posedge clk) begin
        if (reset) begin
            accA <= '{default: '0};
            accB <= '{default: '0};
        end else begin
            for (int o = 0; o < `HL_ODIM; o++) begin
                if (accBank == bankA) begin
                    accA[o] <= clear ? '0 : accA[o] + AccWid'(iCount[o]);
                end else begin
                    accB[o] <= clear ? '0 : accB[o] + AccWid'(iCount[o]);
                end
            end
        end
    end

    // Held bank is the one not accumulating.
    always_comb begin
        for (int o = 0; o < `HL_ODIM; o++) begin
            if (accBank == bankA) begin
                oHeld[o] = accB[o];
            end else begin
                oHeld[o] = accA[o];
            end
        end
    end

endmodule

// File: src/hardActivation.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hardActivation (
    input  logic                  clk,
    input  logic                  reset,
    input  hubLinearPkg::accVec_t iAcc,
    output logic [`HL_OWID-1:0]   oFmap [`HL_ODIM]
);

    localparam int AccWid = `HL_ACC_WID;
    localparam logic [AccWid-1:0] MaxOut = AccWid'((1 << `HL_OWID) - 1);

    // Saturate at the largest output word.
    always_ff @(posedge clk) begin
        if (reset) begin
            oFmap <= '{default: '0};
        end else begin
            for (int o = 0; o < `HL_ODIM; o++) begin
                if (iAcc[o] > MaxOut) begin
                    oFmap[o] <= '1;
                end else begin
                    oFmap[o] <= iAcc[o][`HL_OWID-1:0];
                end
            end
        end
    end

endmodule

// File: src/hubLinearLayer.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hubLinearLayer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  logic                      sel,
    input  logic                      clear,
    input  hubLinearPkg::featureVec_t iFmap,
    input  hubLinearPkg::weightVec_t  iWeig,
    output logic [`HL_OWID-1:0]       oFmap [`HL_ODIM]
);

    import hubLinearPkg::*;

    weightVec_t                   storedWeig;
    logic [`HL_IDIM-1:0]          inBit;
    logic [`HL_ODIM*`HL_IDIM-1:0] prodBit;
    countVec_t                    prodCount;
    accVec_t                      heldAcc;

    weightBuffer u_weightBuffer (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .iWeig (iWeig),
        .oWeig (storedWeig)
    );

    bitstreamEncoder u_encoder (
        .clk   (clk),
        .reset (reset),
        .iFmap (iFmap),
        .iBit  (inBit)
    );

    hubMultiplierArray u_mulArray (
        .clk   (clk),
        .reset (reset),
        .iBit  (inBit),
        .iWeig (storedWeig),
        .oBit  (prodBit)
    );

    // One parallel counter per output feature.
    for (genvar o = 0; o < `HL_ODIM; o++) begin : genPop
        popcountTree u_popcount (
            .clk    (clk),
            .reset  (reset),
            .iBits  (prodBit[o*`HL_IDIM +: `HL_IDIM]),
            .oCount (prodCount[o])
        );
    end

    pingPongAccumulator u_accum (
        .clk    (clk),
        .reset  (reset),
        .sel    (sel),
        .clear  (clear),
        .iCount (prodCount),
        .oHeld  (heldAcc)
    );

    hardActivation u_act (
        .clk   (clk),
        .reset (reset),
        .iAcc  (heldAcc),
        .oFmap (oFmap)
    );

endmodule

// File: dv/hubLinearLayer_assertions.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hubLinearLayer_assertions (
    input logic                     clk,
    input logic                     reset,
    input logic                     load,
    input logic                     sel,
    input logic [`HL_OWID-1:0]      oFmap [`HL_ODIM],
    input hubLinearPkg::weightVec_t storedWeig,
    input hubLinearPkg::accVec_t    heldAcc
);

    import hubLinearPkg::*;

    int assertFails = 0;

    accBank_e accBank;

    assign accBank = sel ? bankB : bankA;

    for (genvar o = 0; o < `HL_ODIM; o++) begin : genOut
        // Output register comes out of reset at zero.
        resetOut: assert property (@(posedge clk) reset |=> (oFmap[o] == '0))
            else begin
                assertFails++;
                $error("oFmap[%0d] is not zero after reset", o);
            end

        // Held bank keeps its total while the same bank accumulates.
        heldStable: assert property (@(posedge clk) disable iff (reset)
            $stable(accBank) |-> $stable(heldAcc[o]))
            else begin
                assertFails++;
                $error("held bank of output %0d changed without a bank swap", o);
            end
    end

    for (genvar w = 0; w < `HL_ODIM * `HL_IDIM; w++) begin : genWeig
        weigHold: assert property (@(posedge clk) disable iff (reset)
            !load |=> $stable(storedWeig[w]))
            else begin
                assertFails++;
                $error("stored weight %0d changed while load was low", w);
            end
    end

endmodule

bind hubLinearLayer hubLinearLayer_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .sel        (sel),
    .oFmap      (oFmap),
    .storedWeig (storedWeig),
    .heldAcc    (heldAcc)
);

// File: dv/hubLinearLayerTb.sv
`timescale 1ns/1ps
`include "hubLinear_cfg.svh"

module hubLinearLayerTb;

    import hubLinearPkg::*;

    localparam int Idim = `HL_IDIM;
    localparam int Odim = `HL_ODIM;
    localparam int Window = 1 << `HL_IWID;
    localparam int MaxOut = (1 << `HL_OWID) - 1;
    localparam int Tol = 2 * Idim;
    localparam int ClearCycles = `HL_POP_STAGES + 1;
    localparam int SettleCycles = `HL_POP_STAGES + 3;
    localparam int NumWindows = 9;
    localparam int WindowCycles = ClearCycles + Window + SettleCycles;
    // Nine windows plus reset and about two thirds more as margin.
    localparam int MaxCycles = (NumWindows * WindowCycles + 100) * 5 / 3;

    logic                clk;
    logic                reset;
    logic                load;
    logic                sel;
    logic                clear;
    featureVec_t         iFmap;
    weightVec_t          iWeig;
    logic [`HL_OWID-1:0] oFmap [Odim];

    int featVal [Idim];
    int weigVal [Odim*Idim];
    int firstExp [Odim];
    int errorCount;
    int errorsBefore;
    int testCount;
    int cycleCount;

    hubLinearLayer dut0 (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .sel   (sel),
        .clear (clear),
        .iFmap (iFmap),
        .iWeig (iWeig),
        .oFmap (oFmap)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > MaxCycles) begin
            $display("Timeout: the tests did not complete within %0d clock cycles", MaxCycles);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic checkValue(input string what, input logic [31:0] got, input int exp,
                              input int tol);
        int diff;
        if ($isunknown(got)) begin
            errorCount++;
            $display("ERROR at time %0t: %s is unknown, expected %0d", $time, what, exp);
        end else begin
            diff = (int'(got) > exp) ? int'(got) - exp : exp - int'(got);
            if (diff > tol) begin
                errorCount++;
                $display("ERROR at time %0t: %s is %0d, expected %0d within %0d",
                         $time, what, got, exp, tol);
            end
        end
    endtask

    // Sum of feature times weight per window clipped to the output range.
    function automatic int expectedOut(input int o);
        int sum;
        sum = 0;
        for (int i = 0; i < Idim; i++) begin
            sum += featVal[i] * weigVal[o * Idim + i];
        end
        sum = sum / Window;
        return (sum > MaxOut) ? MaxOut : sum;
    endfunction

    task automatic endTest(input string name);
        testCount++;
        $display("Test %0d (%s) done with %0d errors", testCount, name, errorCount - errorsBefore);
        errorsBefore = errorCount;
    endtask

    task automatic randomFeatures();
        for (int i = 0; i < Idim; i++) begin
            featVal[i] = int'($urandom % Window);
        end
    endtask

    task automatic randomWeights();
        for (int w = 0; w < Odim * Idim; w++) begin
            weigVal[w] = int'($urandom % Window);
        end
    endtask

    // Load weights, clear the bank, accumulate one full window, then hand it over.
    // Clear stays high until the popcount pipeline holds only the new products.
    task automatic runWindow(input logic bank, input bit watchHeld);
        @(negedge clk);
        for (int i = 0; i < Idim; i++) begin
            iFmap[i] = featVal[i][`HL_IWID-1:0];
        end
        for (int w = 0; w < Odim * Idim; w++) begin
            iWeig[w] = weigVal[w][`HL_IWID-1:0];
        end
        load = 1'b1;
        sel = bank;
        clear = 1'b1;
        @(negedge clk);
        load = 1'b0;
        repeat (ClearCycles - 1) @(negedge clk);
        clear = 1'b0;
        for (int c = 0; c < Window; c++) begin
            @(negedge clk);
            if (watchHeld) begin
                for (int o = 0; o < Odim; o++) begin
                    checkValue($sformatf("held output %0d", o), oFmap[o], firstExp[o], Tol);
                end
            end
        end
        sel = ~bank;
        repeat (SettleCycles) @(negedge clk);
    endtask

    task automatic checkWindow(input string what, input int tol);
        for (int o = 0; o < Odim; o++) begin
            checkValue($sformatf("%s output %0d", what, o), oFmap[o], expectedOut(o), tol);
        end
    endtask

    task automatic testAfterReset();
        for (int o = 0; o < Odim; o++) begin
            checkValue($sformatf("reset output %0d", o), oFmap[o], 0, 0);
        end
        endTest("after reset");
    endtask

    task automatic testZeroFeatures();
        for (int i = 0; i < Idim; i++) begin
            featVal[i] = 0;
        end
        randomWeights();
        runWindow(1'b0, 1'b0);
        checkWindow("zero features", 0);
        endTest("zero features");
    endtask

    task automatic testRandomSets();
        repeat (3) begin
            randomFeatures();
            randomWeights();
            runWindow(1'b0, 1'b0);
            checkWindow("random set", Tol);
        end
        endTest("random sets");
    endtask

    task automatic testSaturation();
        for (int i = 0; i < Idim; i++) begin
            featVal[i] = Window - 1;
        end
        for (int w = 0; w < Odim * Idim; w++) begin
            weigVal[w] = Window - 1;
        end
        runWindow(1'b0, 1'b0);
        checkWindow("saturation", 0);
        endTest("saturation");
    endtask

    task automatic testPingPong();
        randomFeatures();
        randomWeights();
        runWindow(1'b0, 1'b0);
        checkWindow("bank A", Tol);
        for (int o = 0; o < Odim; o++) begin
            firstExp[o] = expectedOut(o);
        end
        // Bank B fills with new features while bank A stays on the output.
        randomFeatures();
        runWindow(1'b1, 1'b1);
        checkWindow("bank B", Tol);
        endTest("ping-pong");
    endtask

    task automatic testWeightReload();
        randomFeatures();
        randomWeights();
        runWindow(1'b0, 1'b0);
        checkWindow("old weights", Tol);
        randomWeights();
        runWindow(1'b0, 1'b0);
        checkWindow("new weights", Tol);
        endTest("weight reload");
    endtask

    initial begin
        void'($urandom(32'h4735_936a));
        clk = 1'b0;
        reset = 1'b1;
        load = 1'b0;
        sel = 1'b0;
        clear = 1'b0;
        iFmap = '{default: '0};
        iWeig = '{default: '0};
        errorCount = 0;
        errorsBefore = 0;
        testCount = 0;
        cycleCount = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        testAfterReset();
        testZeroFeatures();
        testRandomSets();
        testSaturation();
        testPingPong();
        testWeightReload();
        $display("%0d tests, %0d check errors, %0d assertion failures",
                 testCount, errorCount, dut0.u_assertions.assertFails);
        if (errorCount == 0 && dut0.u_assertions.assertFails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: hubLinearLayer.f
+incdir+src
src/hubLinearPkg.sv
src/sobolRng.sv
src/weightBuffer.sv
src/bitstreamEncoder.sv
src/hubMultiplierArray.sv
src/popcountTree.sv
src/pingPongAccumulator.sv
src/hardActivation.sv
src/hubLinearLayer.sv
dv/hubLinearLayer_assertions.sv
dv/hubLinearLayerTb.sv

// File: Bender.yml
package:
  name: hub_linear_layer

sources:
  - include_dirs:
      - src
    files:
      - src/hubLinearPkg.sv
      - src/sobolRng.sv
      - src/weightBuffer.sv
      - src/bitstreamEncoder.sv
      - src/hubMultiplierArray.sv
      - src/popcountTree.sv
      - src/pingPongAccumulator.sv
      - src/hardActivation.sv
      - src/hubLinearLayer.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/hubLinearLayer_assertions.sv
      - dv/hubLinearLayerTb.sv
